// File: hw/exu_alu_pkg.sv
package exu_alu_pkg;

  //////////////////////////////////////////////////
  // Widths

  localparam int xlen_default    = 32;
  localparam int pc_size_default = 32;
  localparam int rfidx_width     = 5;

  // Decode word holds group, op2 select, alu op and branch cond
  localparam int info_width = 7;

  //////////////////////////////////////////////////
  // Encodings

  typedef enum logic [0:0] {
    grp_alu = 1'b0,
    grp_bjp = 1'b1
  } grp_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_xor = 3'd2,
    alu_or  = 3'd3,
    alu_and = 3'd4
  } alu_op_e;

  // Both lt and ge compare as signed
  typedef enum logic [1:0] {
    cond_eq = 2'd0,
    cond_ne = 2'd1,
    cond_lt = 2'd2,
    cond_ge = 2'd3
  } bjp_cond_e;

  // Field order from msb down
  typedef struct packed {
    grp_e      grp;
    logic      op2_imm;
    alu_op_e   alu_op;
    bjp_cond_e cond;
  } info_t;

endpackage

// File: hw/exu_alu_disp.sv
`timescale 1ns/100ps

module exu_alu_disp #(
  parameter int xlen = 32
) (
  // Issue handshake
  input  logic                 i_valid,
  output logic                 o_ready,

  // Decoded instruction and operands
  input  exu_alu_pkg::info_t   i_info,
  input  logic [xlen-1:0]      i_rs1,
  input  logic [xlen-1:0]      i_rs2,
  input  logic [xlen-1:0]      i_imm,

  // Towards commit stage
  input  logic                 i_stage_ready,
  output logic                 o_disp_valid,

  // Towards shared datapath
  output logic                 o_is_bjp,
  output logic [xlen-1:0]      o_op1,
  output logic [xlen-1:0]      o_op2,
  output exu_alu_pkg::alu_op_e   o_alu_op,
  output exu_alu_pkg::bjp_cond_e o_cond
);

  import exu_alu_pkg::*;

  logic is_bjp;
  logic use_imm;

  //////////////////////////////////////////////////
  // Group decode

  // Only place where the group field is looked at
  assign is_bjp = (i_info.grp == grp_bjp);

  // Immediate only for regular ops, branches always compare rs1 and rs2
  assign use_imm = ~is_bjp & i_info.op2_imm;

  //////////////////////////////////////////////////
  // Operand select

  assign o_op1 = i_rs1;
  assign o_op2 = use_imm ? i_imm : i_rs2;

  assign o_is_bjp = is_bjp;
  assign o_alu_op = i_info.alu_op;
  assign o_cond   = i_info.cond;

  //////////////////////////////////////////////////
  // Handshake routing

  // Both groups land in the same output stage
  assign o_disp_valid = i_valid;
  assign o_ready      = i_stage_ready;

endmodule

// File: hw/exu_alu_dpath.sv
`timescale 1ns/100ps

module exu_alu_dpath #(
  parameter int xlen = 32
) (
  input  logic                   i_is_bjp,
  input  logic [xlen-1:0]        i_op1,
  input  logic [xlen-1:0]        i_op2,
  input  exu_alu_pkg::alu_op_e   i_alu_op,
  input  exu_alu_pkg::bjp_cond_e i_cond,

  output logic [xlen-1:0]        o_res,
  output logic                   o_rslv
);

  import exu_alu_pkg::*;

  logic            do_sub;
  logic [xlen-1:0] add_op2;
  logic [xlen-1:0] add_cin;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] xor_res;
  logic [xlen-1:0] or_res;
  logic [xlen-1:0] and_res;
  logic            sign_diff;
  logic            cmp_eq;
  logic            cmp_lt;

  //////////////////////////////////////////////////
  // Shared adder

  // Branches always subtract
  assign do_sub  = i_is_bjp | (i_alu_op == alu_sub);
  assign add_op2 = do_sub ? ~i_op2 : i_op2;
  assign add_cin = {{(xlen-1){1'b0}}, do_sub};
  assign sum     = i_op1 + add_op2 + add_cin;

  //////////////////////////////////////////////////
  // Logic unit

  assign xor_res = i_op1 ^ i_op2;
  assign or_res  = i_op1 | i_op2;
  assign and_res = i_op1 & i_op2;

  //////////////////////////////////////////////////
  // Branch compare

  assign cmp_eq = ~(|xor_res);

  // On differing signs the negative operand is smaller,
  // otherwise the difference cannot overflow
  assign sign_diff = i_op1[xlen-1] ^ i_op2[xlen-1];
  assign cmp_lt    = sign_diff ? i_op1[xlen-1] : sum[xlen-1];

  always_comb begin
    case (i_cond)
      cond_eq: o_rslv = cmp_eq;
      cond_ne: o_rslv = ~cmp_eq;
      cond_lt: o_rslv = cmp_lt;
      default: o_rslv = ~cmp_lt;
    endcase
  end

  //////////////////////////////////////////////////
  // Result select

  always_comb begin
    case (i_alu_op)
      alu_add,
      alu_sub: o_res = sum;
      alu_xor: o_res = xor_res;
      alu_or:  o_res = or_res;
      alu_and: o_res = and_res;
      default: o_res = '0;
    endcase
  end

endmodule

// File: hw/exu_alu_commit.sv
`timescale 1ns/100ps

module exu_alu_commit #(
  parameter int xlen    = 32,
  parameter int pc_size = 32
) (
  input  logic                                clk,
  input  logic                                i_rst_n,

  // From dispatch and datapath
  input  logic                                i_valid,
  output logic                                o_stage_ready,
  input  logic                                i_is_bjp,
  input  logic [xlen-1:0]                     i_res,
  input  logic                                i_rslv,
  input  logic                                i_bjp_prdt,
  input  logic [pc_size-1:0]                  i_pc,
  input  logic [exu_alu_pkg::rfidx_width-1:0] i_rdidx,
  input  logic                                i_rdwen,

  // Commit port
  output logic                                o_cmt_valid,
  input  logic                                i_cmt_ready,
  output logic [pc_size-1:0]                  o_cmt_pc,
  output logic                                o_cmt_bjp,
  output logic                                o_cmt_bjp_prdt,
  output logic                                o_cmt_bjp_rslv,

  // Register write-back port
  output logic                                o_wbck_valid,
  input  logic                                i_wbck_ready,
  output logic [xlen-1:0]                     o_wbck_data,
  output logic [exu_alu_pkg::rfidx_width-1:0] o_wbck_rdidx
);

  logic                                stage_full;
  logic                                load;
  logic                                retire;
  logic                                need_wbck;

  logic                                held_bjp;
  logic [xlen-1:0]                     held_res;
  logic                                held_rslv;
  logic                                held_prdt;
  logic [pc_size-1:0]                  held_pc;
  logic [exu_alu_pkg::rfidx_width-1:0] held_rdidx;
  logic                                held_rdwen;

  //////////////////////////////////////////////////
  // Retire rule

  // Only regular ops write the register file
  assign need_wbck = ~held_bjp & held_rdwen;

  // Commit and write-back must fire in the same cycle
  assign retire = stage_full & i_cmt_ready & (~need_wbck | i_wbck_ready);

  assign o_stage_ready = ~stage_full | retire;
  assign load          = i_valid & o_stage_ready;

  //////////////////////////////////////////////////
  // Stage registers

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      stage_full <= 1'b0;
    end else if (load) begin
      stage_full <= 1'b1;
    end else if (retire) begin
      stage_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      held_bjp   <= i_is_bjp;
      held_res   <= i_res;
      held_rslv  <= i_rslv;
      held_prdt  <= i_bjp_prdt;
      held_pc    <= i_pc;
      held_rdidx <= i_rdidx;
      held_rdwen <= i_rdwen;
    end
  end

  //////////////////////////////////////////////////
  // Output ports

  assign o_cmt_valid  = stage_full & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = stage_full & need_wbck & i_cmt_ready;

  assign o_cmt_pc       = held_pc;
  assign o_cmt_bjp      = held_bjp;
  assign o_cmt_bjp_prdt = held_bjp & held_prdt;
  assign o_cmt_bjp_rslv = held_bjp & held_rslv;

  assign o_wbck_data  = held_res;
  assign o_wbck_rdidx = held_rdidx;

endmodule

// File: hw/exu_alu.sv
`timescale 1ns/100ps

module exu_alu #(
  parameter int xlen    = exu_alu_pkg::xlen_default,
  parameter int pc_size = exu_alu_pkg::pc_size_default
) (
  input  logic                                clk,
  input  logic                                i_rst_n,

  // Issue port
  input  logic                                i_valid,
  output logic                                o_ready,
  input  logic [xlen-1:0]                     i_rs1,
  input  logic [xlen-1:0]                     i_rs2,
  input  logic [xlen-1:0]                     i_imm,
  input  exu_alu_pkg::info_t                  i_info,
  input  logic [pc_size-1:0]                  i_pc,
  input  logic [exu_alu_pkg::rfidx_width-1:0] i_rdidx,
  input  logic                                i_rdwen,
  input  logic                                i_bjp_prdt,

  // Commit port
  output logic                                o_cmt_valid,
  input  logic                                i_cmt_ready,
  output logic [pc_size-1:0]                  o_cmt_pc,
  output logic                                o_cmt_bjp,
  output logic                                o_cmt_bjp_prdt,
  output logic                                o_cmt_bjp_rslv,

  // Register write-back port
  output logic                                o_wbck_valid,
  input  logic                                i_wbck_ready,
  output logic [xlen-1:0]                     o_wbck_data,
  output logic [exu_alu_pkg::rfidx_width-1:0] o_wbck_rdidx
);

  import exu_alu_pkg::*;

  logic            disp_valid;
  logic            stage_ready;
  logic            disp_is_bjp;
  logic [xlen-1:0] disp_op1;
  logic [xlen-1:0] disp_op2;
  alu_op_e         disp_alu_op;
  bjp_cond_e       disp_cond;
  logic [xlen-1:0] dpath_res;
  logic            dpath_rslv;

  //////////////////////////////////////////////////
  // Dispatch

  exu_alu_disp #(
    .xlen (xlen)
  ) u_disp (
    .i_valid       (i_valid),
    .o_ready       (o_ready),
    .i_info        (i_info),
    .i_rs1         (i_rs1),
    .i_rs2         (i_rs2),
    .i_imm         (i_imm),
    .i_stage_ready (stage_ready),
    .o_disp_valid  (disp_valid),
    .o_is_bjp      (disp_is_bjp),
    .o_op1         (disp_op1),
    .o_op2         (disp_op2),
    .o_alu_op      (disp_alu_op),
    .o_cond        (disp_cond)
  );

  //////////////////////////////////////////////////
  // Shared datapath

  exu_alu_dpath #(
    .xlen (xlen)
  ) u_dpath (
    .i_is_bjp (disp_is_bjp),
    .i_op1    (disp_op1),
    .i_op2    (disp_op2),
    .i_alu_op (disp_alu_op),
    .i_cond   (disp_cond),
    .o_res    (dpath_res),
    .o_rslv   (dpath_rslv)
  );

  //////////////////////////////////////////////////
  // Output stage

  exu_alu_commit #(
    .xlen    (xlen),
    .pc_size (pc_size)
  ) u_commit (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_valid        (disp_valid),
    .o_stage_ready  (stage_ready),
    .i_is_bjp       (disp_is_bjp),
    .i_res          (dpath_res),
    .i_rslv         (dpath_rslv),
    .i_bjp_prdt     (i_bjp_prdt),
    .i_pc           (i_pc),
    .i_rdidx        (i_rdidx),
    .i_rdwen        (i_rdwen),
    .o_cmt_valid    (o_cmt_valid),
    .i_cmt_ready    (i_cmt_ready),
    .o_cmt_pc       (o_cmt_pc),
    .o_cmt_bjp      (o_cmt_bjp),
    .o_cmt_bjp_prdt (o_cmt_bjp_prdt),
    .o_cmt_bjp_rslv (o_cmt_bjp_rslv),
    .o_wbck_valid   (o_wbck_valid),
    .i_wbck_ready   (i_wbck_ready),
    .o_wbck_data    (o_wbck_data),
    .o_wbck_rdidx   (o_wbck_rdidx)
  );

endmodule

// File: dv/exu_alu_model.svh
`ifndef EXU_ALU_MODEL_SVH
`define EXU_ALU_MODEL_SVH

// Expected retirement of one instruction
typedef struct packed {
  logic [pc_size-1:0]     pc;
  logic                   bjp;
  logic                   prdt;
  logic                   rslv;
  logic                   wbck;
  logic [xlen-1:0]        data;
  logic [rfidx_width-1:0] rdidx;
} expect_t;

function automatic logic [xlen-1:0] model_alu(input alu_op_e op,
                                              input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
  case (op)
    alu_add: return a + b;
    alu_sub: return a - b;
    alu_xor: return a ^ b;
    alu_or:  return a | b;
    alu_and: return a & b;
    default: return '0;
  endcase
endfunction

// Both ordered compares are signed
function automatic logic model_branch(input bjp_cond_e cond,
                                      input logic [xlen-1:0] a,
                                      input logic [xlen-1:0] b);
  case (cond)
    cond_eq: return a == b;
    cond_ne: return a != b;
    cond_lt: return $signed(a) < $signed(b);
    default: return $signed(a) >= $signed(b);
  endcase
endfunction

function automatic expect_t model_expect(input info_t info,
                                         input logic [xlen-1:0] rs1,
                                         input logic [xlen-1:0] rs2,
                                         input logic [xlen-1:0] imm,
                                         input logic [pc_size-1:0] pc,
                                         input logic [rfidx_width-1:0] rdidx,
                                         input logic rdwen,
                                         input logic prdt);
  expect_t e;
  logic    is_bjp;
  is_bjp  = (info.grp == grp_bjp);
  e.pc    = pc;
  e.bjp   = is_bjp;
  e.prdt  = is_bjp & prdt;
  e.rslv  = is_bjp & model_branch(info.cond, rs1, rs2);
  e.wbck  = ~is_bjp & rdwen;
  e.data  = model_alu(info.alu_op, rs1, info.op2_imm ? imm : rs2);
  e.rdidx = rdidx;
  return e;
endfunction

`endif

// File: dv/tb_exu_alu.sv
`timescale 1ns/100ps

module tb_exu_alu;

  import exu_alu_pkg::*;

  localparam int          xlen    = xlen_default;
  localparam int          pc_size = pc_size_default;
  localparam int          n_instr = 400;
  localparam int          timeout = 200;
  localparam logic [15:0] seed    = 16'd25378;

  `include "exu_alu_model.svh"

  logic                   clk;
  logic                   i_rst_n;
  logic                   i_valid;
  logic                   o_ready;
  logic [xlen-1:0]        i_rs1;
  logic [xlen-1:0]        i_rs2;
  logic [xlen-1:0]        i_imm;
  info_t                  i_info;
  logic [pc_size-1:0]     i_pc;
  logic [rfidx_width-1:0] i_rdidx;
  logic                   i_rdwen;
  logic                   i_bjp_prdt;
  logic                   o_cmt_valid;
  logic                   i_cmt_ready;
  logic [pc_size-1:0]     o_cmt_pc;
  logic                   o_cmt_bjp;
  logic                   o_cmt_bjp_prdt;
  logic                   o_cmt_bjp_rslv;
  logic                   o_wbck_valid;
  logic                   i_wbck_ready;
  logic [xlen-1:0]        o_wbck_data;
  logic [rfidx_width-1:0] o_wbck_rdidx;

  logic [15:0]                         lfsr;
  expect_t                             exp_q[$];
  string                               test_name;
  logic                                accepted;
  logic                                last_stalled;
  logic [pc_size+xlen+rfidx_width+2:0] snap;
  logic [pc_size+xlen+rfidx_width+2:0] held_view;

  exu_alu #(
    .xlen    (xlen),
    .pc_size (pc_size)
  ) dut (.*);

  assign held_view = {o_cmt_pc, o_cmt_bjp, o_cmt_bjp_prdt, o_cmt_bjp_rslv,
                      o_wbck_data, o_wbck_rdidx};

  initial clk = 1'b0;
  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Failure reporting and compare tasks

  task automatic abort_run;
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_failure(input string what);
    $display("%s: %s", test_name, what);
    abort_run();
  endtask

  task automatic check_cmt(input logic [pc_size-1:0] exp_pc, input logic [pc_size-1:0] act_pc,
                           input logic exp_bjp, input logic act_bjp,
                           input logic exp_prdt, input logic act_prdt,
                           input logic exp_rslv, input logic act_rslv);
    string exp_s;
    string act_s;
    if ({exp_pc, exp_bjp, exp_prdt, exp_rslv} !== {act_pc, act_bjp, act_prdt, act_rslv}) begin
      exp_s = $sformatf("pc=%h bjp=%b prdt=%b rslv=%b", exp_pc, exp_bjp, exp_prdt, exp_rslv);
      act_s = $sformatf("pc=%h bjp=%b prdt=%b rslv=%b", act_pc, act_bjp, act_prdt, act_rslv);
      $display("error %s commit expected %s actual %s", test_name, exp_s, act_s);
      abort_run();
    end
  endtask

  task automatic check_wbck(input logic [xlen-1:0] exp_data, input logic [xlen-1:0] act_data,
                            input logic [rfidx_width-1:0] exp_rdidx,
                            input logic [rfidx_width-1:0] act_rdidx);
    if ({exp_data, exp_rdidx} !== {act_data, act_rdidx}) begin
      $display("error %s wbck expected data=%h rd=%0d actual data=%h rd=%0d", test_name,
               exp_data, exp_rdidx, act_data, act_rdidx);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Random source

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] val;
    int          k;
    val = '0;
    for (k = 0; k < nbits; k++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Small values, sign boundaries or anything
  function automatic logic [xlen-1:0] pick_operand();
    logic [1:0] kind;
    logic       msb;
    logic       rest;
    kind = draw(2);
    if (kind == 2'd0) begin
      return draw(2);
    end else if (kind == 2'd1) begin
      msb  = draw(1);
      rest = draw(1);
      return {msb, {(xlen-1){rest}}};
    end
    return draw(xlen);
  endfunction

  // kind 0 is alu only, 1 is branch only, 2 is mixed
  task automatic drive_instr(input int kind);
    logic       grp_bit;
    logic       sel_imm;
    logic [2:0] op;
    logic [1:0] cond;
    grp_bit    = (kind == 2) ? draw(1) : (kind == 1);
    sel_imm    = draw(1);
    op         = draw(3) % 5;
    cond       = draw(2);
    i_info     = info_t'({grp_bit, sel_imm, op, cond});
    i_rs1      = pick_operand();
    i_rs2      = (draw(2) == 0) ? i_rs1 : pick_operand();
    i_imm      = draw(xlen);
    i_pc       = draw(pc_size);
    i_rdidx    = draw(rfidx_width);
    i_rdwen    = draw(1);
    i_bjp_prdt = draw(1);
  endtask

  //////////////////////////////////////////////////
  // Issue and drain

  task automatic run_phase(input string name, input int count, input int kind,
                           input logic busy);
    int sent;
    int stall;
    int cycles;
    sent      = 0;
    stall     = 0;
    test_name = name;
    while (sent < count || i_valid) begin
      @(negedge clk);
      if (accepted) begin
        i_valid  = 1'b0;
        accepted = 1'b0;
      end
      i_cmt_ready  = busy ? draw(1) : 1'b1;
      i_wbck_ready = busy ? draw(1) : 1'b1;
      if (!i_valid && sent < count && (!busy || draw(2) != 0)) begin
        drive_instr(kind);
        i_valid = 1'b1;
        sent++;
      end
      @(posedge clk);
      if (i_valid && o_ready) begin
        accepted = 1'b1;
        stall    = 0;
      end else if (i_valid) begin
        stall++;
        if (stall > timeout)
          report_failure("issue handshake stalled, o_ready stayed low");
      end
    end
    // Let the last result leave the stage
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      i_cmt_ready  = 1'b1;
      i_wbck_ready = 1'b1;
      cycles++;
      if (cycles > timeout)
        report_failure("commit handshake stalled while draining");
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor sampling settled outputs

  always @(posedge clk) begin : monitor
    expect_t head;
    logic    cmt_fire;
    logic    wbck_fire;
    if (i_rst_n) begin
      cmt_fire  = o_cmt_valid & i_cmt_ready;
      wbck_fire = o_wbck_valid & i_wbck_ready;
      if (wbck_fire && !cmt_fire)
        report_failure("write-back fired without its commit");
      if (exp_q.size() == 0) begin
        if (o_cmt_valid || o_wbck_valid || !o_ready)
          report_failure("outputs active with no instruction held");
      end else begin
        if (last_stalled && snap !== held_view)
          report_failure("held outputs changed under back-pressure");
        if (o_ready !== cmt_fire)
          report_failure("o_ready does not follow retirement of the held result");
        if (!cmt_fire && i_cmt_ready && i_wbck_ready)
          report_failure("held instruction did not retire with both readies high");
        if (!exp_q[0].wbck && o_wbck_valid)
          report_failure("write-back valid for an instruction without write-back");
      end
      last_stalled = (exp_q.size() != 0) && !cmt_fire;
      snap         = held_view;
      if (cmt_fire) begin
        head = exp_q.pop_front();
        check_cmt(head.pc, o_cmt_pc, head.bjp, o_cmt_bjp,
                  head.prdt, o_cmt_bjp_prdt, head.rslv, o_cmt_bjp_rslv);
        if (wbck_fire != head.wbck)
          report_failure("write-back handshake does not match the retiring instruction");
        if (head.wbck)
          check_wbck(head.data, o_wbck_data, head.rdidx, o_wbck_rdidx);
      end
      if (i_valid && o_ready) begin
        exp_q.push_back(model_expect(i_info, i_rs1, i_rs2, i_imm, i_pc,
                                     i_rdidx, i_rdwen, i_bjp_prdt));
        if (exp_q.size() > 1)
          report_failure("instruction accepted while the stage was full");
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    lfsr         = seed;
    test_name    = "reset";
    accepted     = 1'b0;
    last_stalled = 1'b0;
    snap         = '0;
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_rs1        = '0;
    i_rs2        = '0;
    i_imm        = '0;
    i_info       = '0;
    i_pc         = '0;
    i_rdidx      = '0;
    i_rdwen      = 1'b0;
    i_bjp_prdt   = 1'b0;
    i_cmt_ready  = 1'b1;
    i_wbck_ready = 1'b1;
    repeat (3) @(negedge clk);
    i_rst_n = 1'b1;
    @(negedge clk);
    if (o_cmt_valid || o_wbck_valid || !o_ready)
      report_failure("outputs not idle after reset");

    run_phase("alu", 120, 0, 1'b0);
    run_phase("branch", 80, 1, 1'b0);
    run_phase("random", n_instr - 200, 2, 1'b1);

    $display("sim passed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+dv
hw/exu_alu_pkg.sv
hw/exu_alu_disp.sv
hw/exu_alu_dpath.sv
hw/exu_alu_commit.sv
hw/exu_alu.sv
dv/tb_exu_alu.sv

// File: Bender.yml
package:
  name: exu_alu

sources:
  - hw/exu_alu_pkg.sv
  - hw/exu_alu_disp.sv
  - hw/exu_alu_dpath.sv
  - hw/exu_alu_commit.sv
  - hw/exu_alu.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_exu_alu.sv
